/* rtl/rt_cfg.svh */
`ifndef RT_CFG_SVH
`define RT_CFG_SVH

// fixed-point format
`define NUM_FRAC_DIGITS 16

// display geometry, kept small for short frames
`define DISPLAY_WIDTH 16
`define DISPLAY_HEIGHT 12
`define H_BITS 4
`define V_BITS 4

// newton steps in the inverse square root
`define ISQRT_ITERS 4

// common fixed-point constants
`define FP_ZERO 32'sh0000_0000
`define FP_ONE 32'sh0001_0000
`define FP_HALF 32'sh0000_8000
`define FP_THREE_HALVES 32'sh0001_8000

// 16.0 and 12.0
`define FP_DISPLAY_WIDTH 32'sh0010_0000
`define FP_DISPLAY_HEIGHT 32'sh000C_0000

// 1/12, truncated to 16 fraction bits
`define FP_INV_DISPLAY_HEIGHT 32'sh0000_1555

`endif

/* rtl/rt_pkg.sv */
`include "rt_cfg.svh"

package rt_pkg;

  // signed fixed point, `NUM_FRAC_DIGITS fraction bits
  typedef logic signed [31:0] fp;

  typedef logic [`H_BITS-1:0] hcount_t;
  typedef logic [`V_BITS-1:0] vcount_t;

  typedef struct packed {
    fp x;
    fp y;
    fp z;
  } vec3;

  function automatic vec3 make_vec3(input fp x, input fp y, input fp z);
    vec3 v;
    v.x = x;
    v.y = y;
    v.z = z;
    return v;
  endfunction

  // full 64-bit product, arithmetic shift, then truncation
  function automatic fp fp_mul(input fp a, input fp b);
    logic signed [63:0] prod;
    prod = a * b;
    return fp'(prod >>> `NUM_FRAC_DIGITS);
  endfunction

  function automatic fp fp_sub(input fp a, input fp b);
    return a - b;
  endfunction

  function automatic vec3 vec3_add(input vec3 a, input vec3 b);
    return make_vec3(a.x + b.x, a.y + b.y, a.z + b.z);
  endfunction

  function automatic vec3 vec3_scaled(input vec3 v, input fp s);
    return make_vec3(fp_mul(v.x, s), fp_mul(v.y, s), fp_mul(v.z, s));
  endfunction

  function automatic fp vec3_dot(input vec3 a, input vec3 b);
    fp sum;
    sum = fp_mul(a.x, b.x);
    sum = sum + fp_mul(a.y, b.y);
    sum = sum + fp_mul(a.z, b.z);
    return sum;
  endfunction

  // right-handed cross product a x b
  function automatic vec3 vec3_cross(input vec3 a, input vec3 b);
    fp cx;
    fp cy;
    fp cz;
    cx = fp_sub(fp_mul(a.y, b.z), fp_mul(a.z, b.y));
    cy = fp_sub(fp_mul(a.z, b.x), fp_mul(a.x, b.z));
    cz = fp_sub(fp_mul(a.x, b.y), fp_mul(a.y, b.x));
    return make_vec3(cx, cy, cz);
  endfunction

endpackage

/* rtl/fp_inv_sqrt_folded.sv */
`timescale 1ns/1ps

`include "rt_cfg.svh"

module fp_inv_sqrt_folded (
  input  logic      clk_in,
  input  logic      rst_in,
  input  rt_pkg::fp a_in,
  input  logic      valid_in,
  output rt_pkg::fp res_out,
  output logic      valid_out,
  output logic      ready_out
);
  import rt_pkg::*;

  localparam int ITER_BITS = $clog2(`ISQRT_ITERS + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEED,
    S_MUL_YY,
    S_MUL_AYY,
    S_UPDATE,
    S_DONE
  } state_t;

  state_t               state;
  logic [ITER_BITS-1:0] iter;

  fp a_q;
  fp y;
  fp t;
  fp seed;
  fp mul_a;
  fp mul_b;
  fp mul_res;

  logic [4:0]        lead;
  logic signed [5:0] exp_q;
  logic signed [5:0] half_exp;
  logic [3:0]        shamt;

  // leading one of the operand gives its binary exponent
  always_comb begin
    lead = '0;
    for (int i = 0; i < 31; i++) begin
      if (a_q[i]) lead = 5'(i);
    end
  end

  // seed is 2^-ceil(e/2), so a*y*y starts in [0.5, 2)
  assign exp_q    = $signed({1'b0, lead}) - 6'sd16;
  assign half_exp = (exp_q + 6'sd1) >>> 1;
  assign shamt    = half_exp[5] ? 4'(-half_exp) : 4'(half_exp);
  assign seed     = half_exp[5] ? (fp'(`FP_ONE) << shamt) : (fp'(`FP_ONE) >> shamt);

  // the one shared multiplier
  always_comb begin
    mul_a = `FP_ZERO;
    mul_b = `FP_ZERO;
    case (state)
      S_MUL_YY: begin
        mul_a = y;
        mul_b = y;
      end
      S_MUL_AYY: begin
        mul_a = a_q;
        mul_b = t;
      end
      S_UPDATE: begin
        mul_a = y;
        // constant multiply, only a shift in hardware
        mul_b = fp_sub(`FP_THREE_HALVES, fp_mul(`FP_HALF, t));
      end
      default: ;
    endcase
  end

  assign mul_res   = fp_mul(mul_a, mul_b);
  assign ready_out = (state == S_IDLE);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state     <= S_IDLE;
      iter      <= '0;
      valid_out <= 1'b0;
    end else begin
      valid_out <= 1'b0;
      case (state)
        S_IDLE:    if (valid_in) state <= S_SEED;
        S_SEED: begin
          iter  <= '0;
          state <= S_MUL_YY;
        end
        S_MUL_YY:  state <= S_MUL_AYY;
        S_MUL_AYY: state <= S_UPDATE;
        S_UPDATE: begin
          if (iter == ITER_BITS'(`ISQRT_ITERS - 1)) begin
            state <= S_DONE;
          end else begin
            iter  <= iter + 1'b1;
            state <= S_MUL_YY;
          end
        end
        S_DONE: begin
          valid_out <= 1'b1;
          state     <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (state == S_IDLE && valid_in) a_q <= a_in;
    if (state == S_SEED) y <= seed;
    if (state == S_MUL_YY || state == S_MUL_AYY) t <= mul_res;
    if (state == S_UPDATE) y <= mul_res;
    if (state == S_DONE) res_out <= y;
  end

endmodule

/* rtl/ray_generator_folded.sv */
`timescale 1ns/1ps

`include "rt_cfg.svh"

module ray_generator_folded (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            valid_in,
  input  rt_pkg::hcount_t hcount_in,
  input  rt_pkg::vcount_t vcount_in,
  input  rt_pkg::vec3     cam_forward_in,
  output logic            valid_out,
  output logic            ready_out,
  output rt_pkg::vec3     ray_direction_out
);
  import rt_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RIGHT,
    ST_UP,
    ST_PXPY,
    ST_SCALE,
    ST_SUM,
    ST_NORM
  } stage_t;

  stage_t stage;

  hcount_t hcount;
  vcount_t vcount;
  vec3     cam_forward;
  vec3     cam_right;
  vec3     cam_up;
  fp       px;
  fp       py;
  vec3     scaled_right;
  vec3     scaled_up;
  vec3     dir_sum;

  // 2h and 2v as fixed point
  fp h2_fp;
  fp v2_fp;

  fp    isq_a;
  fp    isq_res;
  logic isq_valid;
  logic isq_ready;
  logic isq_done;

  fp mult1_a, mult1_b, mult1_res;
  fp mult2_a, mult2_b, mult2_res;
  fp mult3_a, mult3_b, mult3_res;

  assign h2_fp = fp'({hcount, 1'b0}) << `NUM_FRAC_DIGITS;
  assign v2_fp = fp'({vcount, 1'b0}) << `NUM_FRAC_DIGITS;

  // unnormalized direction, stable from ST_SUM until the ray leaves
  assign dir_sum = vec3_add(vec3_add(scaled_right, scaled_up), cam_forward);

  assign isq_a     = vec3_dot(dir_sum, dir_sum);
  assign isq_valid = (stage == ST_SUM) && isq_ready;
  assign ready_out = (stage == ST_IDLE);

  fp_inv_sqrt_folded isqrt_i (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .a_in      (isq_a),
    .valid_in  (isq_valid),
    .res_out   (isq_res),
    .valid_out (isq_done),
    .ready_out (isq_ready)
  );

  assign mult1_res = fp_mul(mult1_a, mult1_b);
  assign mult2_res = fp_mul(mult2_a, mult2_b);
  assign mult3_res = fp_mul(mult3_a, mult3_b);

  // operand select for the three shared multipliers
  always_comb begin
    mult1_a = `FP_ZERO;
    mult1_b = `FP_ZERO;
    mult2_a = `FP_ZERO;
    mult2_b = `FP_ZERO;
    mult3_a = `FP_ZERO;
    mult3_b = `FP_ZERO;
    case (stage)
      ST_PXPY: begin
        mult1_a = fp_sub(h2_fp, `FP_DISPLAY_WIDTH);
        mult1_b = `FP_INV_DISPLAY_HEIGHT;
        mult2_a = fp_sub(v2_fp, `FP_DISPLAY_HEIGHT);
        mult2_b = `FP_INV_DISPLAY_HEIGHT;
      end
      ST_SCALE: begin
        mult1_a = cam_right.x;
        mult1_b = px;
        mult2_a = cam_right.y;
        mult2_b = px;
        mult3_a = cam_right.z;
        mult3_b = px;
      end
      ST_NORM: begin
        mult1_a = dir_sum.x;
        mult1_b = isq_res;
        mult2_a = dir_sum.y;
        mult2_b = isq_res;
        mult3_a = dir_sum.z;
        mult3_b = isq_res;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      stage     <= ST_IDLE;
      valid_out <= 1'b0;
    end else begin
      valid_out <= 1'b0;
      case (stage)
        ST_IDLE:  if (valid_in) stage <= ST_RIGHT;
        ST_RIGHT: stage <= ST_UP;
        ST_UP:    stage <= ST_PXPY;
        ST_PXPY:  stage <= ST_SCALE;
        ST_SCALE: stage <= ST_SUM;
        ST_SUM:   if (isq_ready) stage <= ST_NORM;
        ST_NORM: begin
          if (isq_done) begin
            valid_out <= 1'b1;
            stage     <= ST_IDLE;
          end
        end
        default:  stage <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (stage == ST_IDLE && valid_in) begin
      hcount      <= hcount_in;
      vcount      <= vcount_in;
      cam_forward <= cam_forward_in;
    end
    // world up is +y
    if (stage == ST_RIGHT) begin
      cam_right <= vec3_cross(make_vec3(`FP_ZERO, `FP_ONE, `FP_ZERO), cam_forward);
    end
    if (stage == ST_UP) cam_up <= vec3_cross(cam_forward, cam_right);
    if (stage == ST_PXPY) begin
      px <= mult1_res;
      py <= mult2_res;
    end
    if (stage == ST_SCALE) begin
      scaled_right <= make_vec3(mult1_res, mult2_res, mult3_res);
      scaled_up    <= vec3_scaled(cam_up, py);
    end
    // screen y grows downwards, hence the sign flip
    if (stage == ST_NORM && isq_done) begin
      ray_direction_out <= make_vec3(mult1_res, -mult2_res, mult3_res);
    end
  end

endmodule

/* rtl/pixel_scanner.sv */
`timescale 1ns/1ps

`include "rt_cfg.svh"

module pixel_scanner (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            start_in,
  input  rt_pkg::vec3     cam_forward_in,
  input  logic            gen_ready_in,
  input  logic            gen_valid_in,
  output logic            pix_valid_out,
  output rt_pkg::hcount_t hcount_out,
  output rt_pkg::vcount_t vcount_out,
  output rt_pkg::vec3     cam_forward_out,
  output rt_pkg::hcount_t ray_hcount_out,
  output rt_pkg::vcount_t ray_vcount_out,
  output logic            frame_done_out,
  output logic            busy_out
);
  import rt_pkg::*;

  typedef enum logic [1:0] {SC_IDLE, SC_ISSUE, SC_WAIT} scan_t;

  scan_t state;
  logic  ray_last;
  logic  want_issue;
  logic  issue;

  assign ray_last = (ray_hcount_out == hcount_t'(`DISPLAY_WIDTH - 1)) &&
                    (ray_vcount_out == vcount_t'(`DISPLAY_HEIGHT - 1));

  // next pixel goes out as soon as the generator returns a ray
  assign want_issue = (state == SC_ISSUE) ||
                      (state == SC_WAIT && gen_valid_in && !ray_last);
  assign issue      = want_issue && gen_ready_in;

  assign frame_done_out = (state == SC_WAIT) && gen_valid_in && ray_last;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state         <= SC_IDLE;
      pix_valid_out <= 1'b0;
      busy_out      <= 1'b0;
      hcount_out    <= '0;
      vcount_out    <= '0;
    end else begin
      pix_valid_out <= issue;
      // generator takes the pixel on this edge, so step the raster
      if (pix_valid_out) begin
        if (hcount_out == hcount_t'(`DISPLAY_WIDTH - 1)) begin
          hcount_out <= '0;
          vcount_out <= vcount_out + 1'b1;
        end else begin
          hcount_out <= hcount_out + 1'b1;
        end
      end
      case (state)
        SC_IDLE: begin
          if (start_in) begin
            hcount_out <= '0;
            vcount_out <= '0;
            busy_out   <= 1'b1;
            state      <= SC_ISSUE;
          end
        end
        SC_ISSUE: if (issue) state <= SC_WAIT;
        SC_WAIT: begin
          if (frame_done_out) begin
            busy_out <= 1'b0;
            state    <= SC_IDLE;
          end else if (gen_valid_in && !issue) begin
            state <= SC_ISSUE;
          end
        end
        default: state <= SC_IDLE;
      endcase
    end
  end

  // frame camera and tag of the pixel in flight
  always_ff @(posedge clk_in) begin
    if (state == SC_IDLE && start_in) cam_forward_out <= cam_forward_in;
    if (pix_valid_out) begin
      ray_hcount_out <= hcount_out;
      ray_vcount_out <= vcount_out;
    end
  end

endmodule

/* rtl/ray_gen_top.sv */
`timescale 1ns/1ps

module ray_gen_top (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            start_in,
  input  rt_pkg::vec3     cam_forward_in,
  output logic            ray_valid_out,
  output rt_pkg::vec3     ray_direction_out,
  output rt_pkg::hcount_t ray_hcount_out,
  output rt_pkg::vcount_t ray_vcount_out,
  output logic            frame_done_out,
  output logic            busy_out
);
  import rt_pkg::*;

  // scanner to generator
  logic    pix_valid;
  hcount_t pix_hcount;
  vcount_t pix_vcount;
  vec3     pix_forward;
  logic    gen_ready;

  pixel_scanner scanner_i (
    .clk_in          (clk_in),
    .rst_in          (rst_in),
    .start_in        (start_in),
    .cam_forward_in  (cam_forward_in),
    .gen_ready_in    (gen_ready),
    .gen_valid_in    (ray_valid_out),
    .pix_valid_out   (pix_valid),
    .hcount_out      (pix_hcount),
    .vcount_out      (pix_vcount),
    .cam_forward_out (pix_forward),
    .ray_hcount_out  (ray_hcount_out),
    .ray_vcount_out  (ray_vcount_out),
    .frame_done_out  (frame_done_out),
    .busy_out        (busy_out)
  );

  ray_generator_folded generator_i (
    .clk_in            (clk_in),
    .rst_in            (rst_in),
    .valid_in          (pix_valid),
    .hcount_in         (pix_hcount),
    .vcount_in         (pix_vcount),
    .cam_forward_in    (pix_forward),
    .valid_out         (ray_valid_out),
    .ready_out         (gen_ready),
    .ray_direction_out (ray_direction_out)
  );

endmodule

/* tb/ray_gen_props.sv */
`timescale 1ns/1ps

module ray_gen_props (
  input logic clk_in,
  input logic rst_in,
  input logic ray_valid,
  input logic frame_done,
  input logic busy,
  input logic gen_valid,
  input logic gen_ready
);

  // one strobe per generator pass
  no_back_to_back_rays: assert property (
    @(posedge clk_in) disable iff (rst_in) ray_valid |=> !ray_valid
  ) else $error("ray_valid_out high on two cycles in a row");

  // last ray closes the frame
  done_with_last_ray: assert property (
    @(posedge clk_in) disable iff (rst_in) frame_done |-> ray_valid ##1 !busy
  ) else $error("frame_done_out without ray_valid_out or busy_out still high after it");

  // scanner only issues into an idle generator
  issue_when_ready: assert property (
    @(posedge clk_in) disable iff (rst_in) gen_valid |-> gen_ready
  ) else $error("generator valid_in while ready_out is low");

  ray_while_busy: assert property (
    @(posedge clk_in) disable iff (rst_in) ray_valid |-> busy
  ) else $error("ray_valid_out while busy_out is low");

endmodule

bind ray_gen_top ray_gen_props props_i (
  .clk_in     (clk_in),
  .rst_in     (rst_in),
  .ray_valid  (ray_valid_out),
  .frame_done (frame_done_out),
  .busy       (busy_out),
  .gen_valid  (pix_valid),
  .gen_ready  (gen_ready)
);

/* tb/ray_gen_tb.sv */
`timescale 1ns/1ps

`include "rt_cfg.svh"

module ray_gen_tb;
  import rt_pkg::*;

  localparam int NUM_FRAMES   = 4;
  localparam int FRAME_PIXELS = `DISPLAY_WIDTH * `DISPLAY_HEIGHT;
  localparam int CENTRE_IDX   = (`DISPLAY_HEIGHT / 2) * `DISPLAY_WIDTH + `DISPLAY_WIDTH / 2;
  localparam int WATCHDOG_NS  = NUM_FRAMES * FRAME_PIXELS * 40 * 4;
  // 2^-8 in fixed point
  localparam fp LEN_TOL = 32'sh0000_0100;

  logic    clk_in;
  logic    rst_in;
  logic    start_in;
  vec3     cam_forward_in;
  logic    ray_valid_out;
  vec3     ray_direction_out;
  hcount_t ray_hcount_out;
  vcount_t ray_vcount_out;
  logic    frame_done_out;
  logic    busy_out;

  integer seed;
  int     test_errors;
  int     total_errors;
  int     tests_run;
  vec3    centre_ray;

  ray_gen_top dut_i (
    .clk_in            (clk_in),
    .rst_in            (rst_in),
    .start_in          (start_in),
    .cam_forward_in    (cam_forward_in),
    .ray_valid_out     (ray_valid_out),
    .ray_direction_out (ray_direction_out),
    .ray_hcount_out    (ray_hcount_out),
    .ray_vcount_out    (ray_vcount_out),
    .frame_done_out    (frame_done_out),
    .busy_out          (busy_out)
  );

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: frames did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  // seed 2^-ceil(e/2) from the leading one, then newton steps
  function automatic fp inv_sqrt_ref(input fp a);
    int msb;
    int e;
    int half;
    fp  y;
    fp  t;
    msb = 0;
    for (int i = 30; i > 0; i--) begin
      if (a[i]) begin
        msb = i;
        break;
      end
    end
    e    = msb - `NUM_FRAC_DIGITS;
    half = (e >= 0) ? (e + 1) / 2 : -((-e) / 2);
    y    = (half < 0) ? (`FP_ONE <<< (-half)) : (`FP_ONE >>> half);
    for (int k = 0; k < `ISQRT_ITERS; k++) begin
      t = fp_mul(a, fp_mul(y, y));
      y = fp_mul(y, fp_sub(`FP_THREE_HALVES, fp_mul(`FP_HALF, t)));
    end
    return y;
  endfunction

  function automatic vec3 expected_ray(input vec3 f, input int h, input int v);
    vec3 right;
    vec3 up;
    vec3 sum;
    vec3 d;
    fp   px;
    fp   py;
    right = vec3_cross(make_vec3(`FP_ZERO, `FP_ONE, `FP_ZERO), f);
    up    = vec3_cross(f, right);
    px    = fp_mul(fp_sub(fp'((2 * h) <<< `NUM_FRAC_DIGITS), `FP_DISPLAY_WIDTH),
                   `FP_INV_DISPLAY_HEIGHT);
    py    = fp_mul(fp_sub(fp'((2 * v) <<< `NUM_FRAC_DIGITS), `FP_DISPLAY_HEIGHT),
                   `FP_INV_DISPLAY_HEIGHT);
    sum   = vec3_add(vec3_add(vec3_scaled(right, px), vec3_scaled(up, py)), f);
    d     = vec3_scaled(sum, inv_sqrt_ref(vec3_dot(sum, sum)));
    // screen y points down
    d.y   = -d.y;
    return d;
  endfunction

  task automatic pick_forward(output vec3 f);
    vec3 raw;
    raw.x = fp'($random(seed) % 32768);
    raw.y = fp'($random(seed) % 32768);
    // z in [0.5, 1) keeps it away from up
    raw.z = fp'(32768 + ($random(seed) & 32'h7fff));
    f     = vec3_scaled(raw, inv_sqrt_ref(vec3_dot(raw, raw)));
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) $display("test %s: ok", name);
    else $display("test %s: %0d failed checks", name, test_errors);
    total_errors += test_errors;
    tests_run++;
  endtask

  task automatic run_frame(input string name, input vec3 fwd, input bit restart);
    int    idx;
    int    h;
    int    v;
    fp     len2;
    vec3   expect_dir;
    vec3   other;
    test_errors = 0;
    idx         = 0;
    @(posedge clk_in);
    #1;
    cam_forward_in = fwd;
    start_in       = 1'b1;
    @(posedge clk_in);
    #1;
    start_in = 1'b0;
    while (!frame_done_out || !ray_valid_out) begin
      @(negedge clk_in);
      if (ray_valid_out) begin
        h          = idx % `DISPLAY_WIDTH;
        v          = idx / `DISPLAY_WIDTH;
        expect_dir = expected_ray(fwd, h, v);
        if (ray_direction_out !== expect_dir) begin
          $display("[FAIL] %s ray %0d: expected %h, got %h", name, idx, expect_dir,
                   ray_direction_out);
          test_errors++;
        end
        if (ray_hcount_out !== hcount_t'(h) || ray_vcount_out !== vcount_t'(v)) begin
          $display("[FAIL] %s ray %0d pixel: expected (%0d,%0d), got (%0d,%0d)", name, idx,
                   h, v, ray_hcount_out, ray_vcount_out);
          test_errors++;
        end
        len2 = vec3_dot(ray_direction_out, ray_direction_out);
        if (len2 > `FP_ONE + LEN_TOL || len2 < `FP_ONE - LEN_TOL) begin
          $display("[FAIL] %s ray %0d length: expected %h +/- %h, got %h", name, idx,
                   `FP_ONE, LEN_TOL, len2);
          test_errors++;
        end
        if (frame_done_out !== (idx == FRAME_PIXELS - 1)) begin
          $display("[FAIL] %s ray %0d frame_done: expected %b, got %b", name, idx,
                   idx == FRAME_PIXELS - 1, frame_done_out);
          test_errors++;
        end
        if (idx == CENTRE_IDX) centre_ray = ray_direction_out;
        idx++;
        if (restart && idx == 60) begin
          // second start mid frame with a different camera
          pick_forward(other);
          @(posedge clk_in);
          #1;
          cam_forward_in = other;
          start_in       = 1'b1;
          @(posedge clk_in);
          #1;
          start_in = 1'b0;
        end
      end
    end
    @(negedge clk_in);
    if (busy_out !== 1'b0) begin
      $display("[FAIL] %s busy_out after last ray: expected 0, got %b", name, busy_out);
      test_errors++;
    end
    // nothing may follow the last ray
    repeat (30) begin
      @(negedge clk_in);
      if (ray_valid_out || frame_done_out) begin
        $display("%s: ray or frame done seen after the end of the frame", name);
        test_errors++;
      end
    end
    if (idx != FRAME_PIXELS) begin
      $display("[FAIL] %s ray count: expected %0d, got %0d", name, FRAME_PIXELS, idx);
      test_errors++;
    end
    finish_test(name);
  endtask

  initial begin
    vec3 fwd;
    seed           = 32'h9a5e7138;
    rst_in         = 1'b1;
    start_in       = 1'b0;
    cam_forward_in = '0;
    total_errors   = 0;
    tests_run      = 0;
    repeat (3) @(posedge clk_in);
    #1;
    rst_in = 1'b0;

    test_errors = 0;
    @(negedge clk_in);
    if (busy_out !== 1'b0 || ray_valid_out !== 1'b0 || frame_done_out !== 1'b0) begin
      $display("[FAIL] reset_state: expected 000, got %b%b%b", busy_out, ray_valid_out,
               frame_done_out);
      test_errors++;
    end
    finish_test("reset_state");

    run_frame("frame_axis", make_vec3(`FP_ZERO, `FP_ZERO, `FP_ONE), 1'b0);
    test_errors = 0;
    if (centre_ray !== make_vec3(`FP_ZERO, `FP_ZERO, `FP_ONE)) begin
      $display("[FAIL] centre_pixel: expected %h, got %h",
               make_vec3(`FP_ZERO, `FP_ZERO, `FP_ONE), centre_ray);
      test_errors++;
    end
    finish_test("centre_pixel");

    for (int n = 0; n < NUM_FRAMES - 2; n++) begin
      pick_forward(fwd);
      run_frame($sformatf("frame_random_%0d", n), fwd, 1'b0);
    end
    pick_forward(fwd);
    run_frame("frame_restart_ignored", fwd, 1'b1);

    $display("tests run: %0d, failed checks: %0d", tests_run, total_errors);
    if (total_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* ray_gen_top.f */
+incdir+rtl
rtl/rt_pkg.sv
rtl/fp_inv_sqrt_folded.sv
rtl/ray_generator_folded.sv
rtl/pixel_scanner.sv
rtl/ray_gen_top.sv
tb/ray_gen_props.sv
tb/ray_gen_tb.sv

/* Makefile */
SOURCES := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vray_gen_tb: ray_gen_top.f $(SOURCES)
	verilator --binary --timing --assert -f ray_gen_top.f --top-module ray_gen_tb -o Vray_gen_tb

run: obj_dir/Vray_gen_tb
	./obj_dir/Vray_gen_tb | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
